// File: Bender.yml
package:
  name: mips_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mips_pkg.sv
      - hdl/control.sv
      - hdl/alu_control.sv
      - hdl/alu.sv
      - hdl/reg_file.sv
      - hdl/mips_core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/mips_core_props.sv
      - tb/mips_core_tb.sv

// File: hdl/alu.sv
// MIPS 32-bit ALU
// Add, subtract, bitwise ops and signed/unsigned set-less-than
// Zero flag feeds the branch decision

`timescale 1ns/10ps

`include "mips_defs.svh"

module alu (
  input  logic [`MIPS_XLEN-1:0] i_a,
  input  logic [`MIPS_XLEN-1:0] i_b,
  input  mips_pkg::alu_fn_e     i_fn,
  output logic [`MIPS_XLEN-1:0] o_result,
  output logic                  o_zero
);

  import mips_pkg::*;

  // Compare results, one bit each
  logic lt_signed;
  logic lt_unsigned;

  assign lt_signed   = $signed(i_a) < $signed(i_b);
  assign lt_unsigned = i_a < i_b;

  always_comb begin
    case (i_fn)
      ALU_ADD:  o_result = i_a + i_b;
      ALU_SUB:  o_result = i_a - i_b;
      ALU_AND:  o_result = i_a & i_b;
      ALU_OR:   o_result = i_a | i_b;
      ALU_XOR:  o_result = i_a ^ i_b;
      ALU_NOR:  o_result = ~(i_a | i_b);
      // Compares return 0 or 1
      ALU_SLT:  o_result = {{(`MIPS_XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: o_result = {{(`MIPS_XLEN-1){1'b0}}, lt_unsigned};
      default:  o_result = '0;
    endcase
  end

  // High on an all-zero result
  assign o_zero = (o_result == '0);

endmodule

// File: hdl/alu_control.sv
// MIPS ALU control
// Picks one ALU function from aluop, the other code and the funct field

`timescale 1ns/10ps

module alu_control (
  input  mips_pkg::aluop_e     i_aluop,
  input  mips_pkg::alu_other_e i_other,
  input  logic [5:0]           i_funct,
  output mips_pkg::alu_fn_e    o_alu_fn
);

  import mips_pkg::*;

  always_comb begin
    // Address add is the fallback for anything unknown
    o_alu_fn = ALU_ADD;

    case (i_aluop)
      // Loads and stores, base plus offset
      ALUOP_MEM: o_alu_fn = ALU_ADD;

      // R-type, funct decides
      ALUOP_RTYPE: begin
        case (i_funct)
          FN_ADD, FN_ADDU: o_alu_fn = ALU_ADD;
          FN_SUB, FN_SUBU: o_alu_fn = ALU_SUB;
          FN_AND:          o_alu_fn = ALU_AND;
          FN_OR:           o_alu_fn = ALU_OR;
          FN_XOR:          o_alu_fn = ALU_XOR;
          FN_NOR:          o_alu_fn = ALU_NOR;
          FN_SLT:          o_alu_fn = ALU_SLT;
          FN_SLTU:         o_alu_fn = ALU_SLTU;
          default:         o_alu_fn = ALU_ADD;
        endcase
      end

      // Immediates and branches, other decides
      ALUOP_IMM: begin
        case (i_other)
          OTH_ADD:          o_alu_fn = ALU_ADD;
          OTH_AND:          o_alu_fn = ALU_AND;
          OTH_OR:           o_alu_fn = ALU_OR;
          OTH_XOR:          o_alu_fn = ALU_XOR;
          // Equality test through the zero flag
          OTH_BEQ, OTH_BNE: o_alu_fn = ALU_SUB;
          OTH_SLT:          o_alu_fn = ALU_SLT;
          default:          o_alu_fn = ALU_ADD;
        endcase
      end

      default: o_alu_fn = ALU_ADD;
    endcase
  end

endmodule

// File: hdl/control.sv
// MIPS main control decoder
// Turns the primary opcode into the WB/MB/EX control bundle
// Unrecognised opcodes leave the bundle all zero and run as a NOP

`timescale 1ns/10ps

module control (
  input  logic [5:0]      i_con_instru,
  output mips_pkg::ctrl_t o_con
);

  import mips_pkg::*;

  // WB group: regwrite, memtoreg
  // MB group: memread, memwrite, branch
  // EX group: regdst, alusrc, aluop, other

  always_comb begin
    // Everything off unless an opcode class claims it
    o_con = '0;

    casez (i_con_instru)
      ////////////////////////////////////////////////////////////
      // Arithmetic and R-type
      ////////////////////////////////////////////////////////////

      // ADD, SUB, logic ops and set-less-than, all via funct
      OP_RTYPE: begin
        o_con.regdst   = 1'b1;
        o_con.regwrite = 1'b1;
        o_con.aluop    = ALUOP_RTYPE;
      end

      // ADDI behaves as ADDIU, no overflow trap
      OP_ADDI, OP_ADDIU: begin
        o_con.alusrc   = 1'b1;
        o_con.regwrite = 1'b1;
        o_con.aluop    = ALUOP_IMM;
        o_con.other    = OTH_ADD;
      end

      // Signed compare against sign-extended immediate
      OP_SLTI: begin
        o_con.alusrc   = 1'b1;
        o_con.regwrite = 1'b1;
        o_con.aluop    = ALUOP_IMM;
        o_con.other    = OTH_SLT;
      end

      ////////////////////////////////////////////////////////////
      // Logical immediates
      ////////////////////////////////////////////////////////////

      // Immediate is zero-extended in the core for these three
      OP_ANDI: begin
        o_con.alusrc   = 1'b1;
        o_con.regwrite = 1'b1;
        o_con.aluop    = ALUOP_IMM;
        o_con.other    = OTH_AND;
      end
      OP_ORI: begin
        o_con.alusrc   = 1'b1;
        o_con.regwrite = 1'b1;
        o_con.aluop    = ALUOP_IMM;
        o_con.other    = OTH_OR;
      end
      OP_XORI: begin
        o_con.alusrc   = 1'b1;
        o_con.regwrite = 1'b1;
        o_con.aluop    = ALUOP_IMM;
        o_con.other    = OTH_XOR;
      end

      ////////////////////////////////////////////////////////////
      // Memory, matched by class
      ////////////////////////////////////////////////////////////

      // Any 100xxx is a load
      6'b100???: begin
        o_con.memread  = 1'b1;
        o_con.memtoreg = 1'b1;
        o_con.regwrite = 1'b1;
        o_con.alusrc   = 1'b1;
        o_con.aluop    = ALUOP_MEM;
      end

      // Any 101xxx is a store
      6'b101???: begin
        o_con.memwrite = 1'b1;
        o_con.alusrc   = 1'b1;
        o_con.aluop    = ALUOP_MEM;
      end

      // Branches compare rs and rt by subtraction
      OP_BEQ: begin
        o_con.branch = 1'b1;
        o_con.aluop  = ALUOP_IMM;
        o_con.other  = OTH_BEQ;
      end
      OP_BNE: begin
        o_con.branch = 1'b1;
        o_con.aluop  = ALUOP_IMM;
        o_con.other  = OTH_BNE;
      end

      default: begin
        // NOP, bundle stays zero
      end
    endcase
  end

endmodule

// File: hdl/mips_core.sv
// MIPS single-cycle integer core
// PC, immediate extension, branch decision and write-back around the
// control, ALU control, ALU and register file blocks
// One instruction completes on every rising clock edge

`timescale 1ns/10ps

`include "mips_defs.svh"

module mips_core (
  input  logic                i_clk,
  input  logic                i_reset,
  input  logic [31:0]         i_instr,
  output logic [31:0]         o_pc,
  output mips_pkg::dmem_req_t o_dmem,
  output logic                o_dmem_re,
  input  logic [31:0]         i_dmem_rdata
);

  import mips_pkg::*;

  ////////////////////////////////////////////////////////////
  // Instruction fields
  ////////////////////////////////////////////////////////////

  logic [`MIPS_REG_AW-1:0] rs;
  logic [`MIPS_REG_AW-1:0] rt;
  logic [`MIPS_REG_AW-1:0] rd;
  logic [15:0]             imm;

  assign rs  = i_instr[25:21];
  assign rt  = i_instr[20:16];
  assign rd  = i_instr[15:11];
  assign imm = i_instr[15:0];

  // Decode and datapath nets
  ctrl_t                   ctrl;
  alu_fn_e                 alu_fn;
  logic [`MIPS_XLEN-1:0]   rdata1;
  logic [`MIPS_XLEN-1:0]   rdata2;
  logic [`MIPS_XLEN-1:0]   imm_sext;
  logic [`MIPS_XLEN-1:0]   imm_ext;
  logic                    imm_zext;
  logic [`MIPS_XLEN-1:0]   alu_b;
  logic [`MIPS_XLEN-1:0]   alu_result;
  logic                    alu_zero;
  logic [`MIPS_REG_AW-1:0] wr_addr;
  logic [`MIPS_XLEN-1:0]   wb_data;
  logic                    reg_we;
  logic [`MIPS_XLEN-1:0]   pc_plus4;
  logic [`MIPS_XLEN-1:0]   br_target;
  logic                    br_taken;
  logic [`MIPS_XLEN-1:0]   pc_next;

  control u_control (
    .i_con_instru (i_instr[31:26]),
    .o_con        (ctrl)
  );

  alu_control u_alu_control (
    .i_aluop  (ctrl.aluop),
    .i_other  (ctrl.other),
    .i_funct  (i_instr[5:0]),
    .o_alu_fn (alu_fn)
  );

  // Logical immediates are zero-extended, the rest sign-extended
  assign imm_sext = {{(`MIPS_XLEN-16){imm[15]}}, imm};
  assign imm_zext = ctrl.alusrc && (ctrl.other inside {OTH_AND, OTH_OR, OTH_XOR});
  assign imm_ext  = imm_zext ? {{(`MIPS_XLEN-16){1'b0}}, imm} : imm_sext;
  assign alu_b    = ctrl.alusrc ? imm_ext : rdata2;

  alu u_alu (
    .i_a      (rdata1),
    .i_b      (alu_b),
    .i_fn     (alu_fn),
    .o_result (alu_result),
    .o_zero   (alu_zero)
  );

  ////////////////////////////////////////////////////////////
  // Write-back
  ////////////////////////////////////////////////////////////

  // rd for R-type, rt otherwise
  assign wr_addr = ctrl.regdst ? rd : rt;
  assign wb_data = ctrl.memtoreg ? i_dmem_rdata : alu_result;
  assign reg_we  = ctrl.regwrite && !i_reset;

  reg_file u_reg_file (
    .i_clk    (i_clk),
    .i_we     (reg_we),
    .i_waddr  (wr_addr),
    .i_raddr1 (rs),
    .i_raddr2 (rt),
    .i_wdata  (wb_data),
    .o_rdata1 (rdata1),
    .o_rdata2 (rdata2)
  );

  // Data memory, address from ALU, store data from rt
  always_comb begin
    o_dmem.we    = ctrl.memwrite && !i_reset;
    o_dmem.addr  = alu_result;
    o_dmem.wdata = rdata2;
  end
  assign o_dmem_re = ctrl.memread && !i_reset;

  ////////////////////////////////////////////////////////////
  // Next PC, no delay slot
  ////////////////////////////////////////////////////////////

  assign pc_plus4  = o_pc + `MIPS_XLEN'd4;
  assign br_target = pc_plus4 + {imm_sext[`MIPS_XLEN-3:0], 2'b00};
  // BEQ on zero, BNE on nonzero
  assign br_taken  = ctrl.branch &&
                     (((ctrl.other == OTH_BEQ) && alu_zero) ||
                      ((ctrl.other == OTH_BNE) && !alu_zero));
  assign pc_next   = br_taken ? br_target : pc_plus4;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_pc <= `MIPS_RESET_PC;
    end else begin
      o_pc <= pc_next;
    end
  end

endmodule

// File: hdl/mips_defs.svh
// MIPS core widths and reset constants
// Shared by the package, the RTL and the testbench

`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Data path and address width
`define MIPS_XLEN 32

// Register file size
`define MIPS_NREG 32

// Register index width, log2 of MIPS_NREG
`define MIPS_REG_AW 5

// First fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

`endif

// File: hdl/mips_pkg.sv
// MIPS core shared types
// Opcode, funct and ALU encodings plus the control and data memory bundles

`include "mips_defs.svh"

package mips_pkg;

  ////////////////////////////////////////////////////////////
  // Instruction encodings
  ////////////////////////////////////////////////////////////

  // Primary opcodes, bits 31:26
  typedef enum logic [5:0] {
    OP_RTYPE = 6'b000000,
    OP_BEQ   = 6'b000100,
    OP_BNE   = 6'b000101,
    OP_ADDI  = 6'b001000,
    OP_ADDIU = 6'b001001,
    OP_SLTI  = 6'b001010,
    OP_ANDI  = 6'b001100,
    OP_ORI   = 6'b001101,
    OP_XORI  = 6'b001110,
    OP_LW    = 6'b100011,
    OP_SW    = 6'b101011
  } opcode_e;

  // R-type funct field, bits 5:0
  typedef enum logic [5:0] {
    FN_ADD  = 6'b100000,
    FN_ADDU = 6'b100001,
    FN_SUB  = 6'b100010,
    FN_SUBU = 6'b100011,
    FN_AND  = 6'b100100,
    FN_OR   = 6'b100101,
    FN_XOR  = 6'b100110,
    FN_NOR  = 6'b100111,
    FN_SLT  = 6'b101010,
    FN_SLTU = 6'b101011
  } funct_e;

  ////////////////////////////////////////////////////////////
  // ALU control encodings
  ////////////////////////////////////////////////////////////

  // Main decoder to ALU control, 01 is unused
  typedef enum logic [1:0] {
    ALUOP_MEM   = 2'b00,
    ALUOP_RTYPE = 2'b10,
    ALUOP_IMM   = 2'b11
  } aluop_e;

  // Sub-operation for immediate and branch classes
  typedef enum logic [3:0] {
    OTH_ADD = 4'b0000,
    OTH_AND = 4'b0001,
    OTH_OR  = 4'b0010,
    OTH_XOR = 4'b0011,
    OTH_BEQ = 4'b0100,
    OTH_BNE = 4'b0101,
    OTH_SLT = 4'b0110
  } alu_other_e;

  // Function actually executed by the ALU
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
    ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU
  } alu_fn_e;

  ////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////

  // Control word, WB then MB then EX group, 13 bits
  typedef struct packed {
    logic       regwrite;
    logic       memtoreg;
    logic       memread;
    logic       memwrite;
    logic       branch;
    logic       regdst;
    logic       alusrc;
    aluop_e     aluop;
    alu_other_e other;
  } ctrl_t;

  // Data memory request, 65 bits
  typedef struct packed {
    logic                  we;
    logic [`MIPS_XLEN-1:0] addr;
    logic [`MIPS_XLEN-1:0] wdata;
  } dmem_req_t;

endpackage

// File: hdl/reg_file.sv
// MIPS register file
// 32 x 32 bits, two combinational read ports and one write port
// Register $0 reads as zero and ignores writes

`timescale 1ns/10ps

`include "mips_defs.svh"

module reg_file (
  input  logic                    i_clk,
  input  logic                    i_we,
  input  logic [`MIPS_REG_AW-1:0] i_waddr,
  input  logic [`MIPS_REG_AW-1:0] i_raddr1,
  input  logic [`MIPS_REG_AW-1:0] i_raddr2,
  input  logic [`MIPS_XLEN-1:0]   i_wdata,
  output logic [`MIPS_XLEN-1:0]   o_rdata1,
  output logic [`MIPS_XLEN-1:0]   o_rdata2
);

  // Storage, contents undefined until written
  logic [`MIPS_XLEN-1:0] regs [`MIPS_NREG];

  // Write port, $0 dropped
  always_ff @(posedge i_clk) begin
    if (i_we && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // Read ports
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// File: mips_core.f
+incdir+hdl
hdl/mips_pkg.sv
hdl/control.sv
hdl/alu_control.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/mips_core.sv
tb/mips_core_props.sv
tb/mips_core_tb.sv

// File: tb/mips_core_props.sv
// Bound assertions for the MIPS core
// Reset gating, PC after reset and the zero register reads

`timescale 1ns/10ps

`include "mips_defs.svh"

module mips_core_props (
  input logic                    i_clk,
  input logic                    i_reset,
  input logic [31:0]             i_pc,
  input mips_pkg::dmem_req_t     i_dmem,
  input logic                    i_dmem_re,
  input logic                    i_reg_we,
  input logic [`MIPS_REG_AW-1:0] i_raddr1,
  input logic [`MIPS_REG_AW-1:0] i_raddr2,
  input logic [`MIPS_XLEN-1:0]   i_rdata1,
  input logic [`MIPS_XLEN-1:0]   i_rdata2
);

  // Failed assertions so far, summed into the end of run result
  int n_assert_fail = 0;

  // No side effects while reset is held
  a_reset_quiet: assert property (@(posedge i_clk)
    i_reset |-> (!i_dmem.we && !i_dmem_re && !i_reg_we))
    else begin
      $error("memory strobe or register write while reset is high");
      n_assert_fail++;
    end

  // First fetch after reset
  a_pc_after_reset: assert property (@(posedge i_clk)
    $fell(i_reset) |-> (i_pc == `MIPS_RESET_PC))
    else begin
      $error("PC differs from the reset value after reset");
      n_assert_fail++;
    end

  // Word aligned fetch
  a_pc_aligned: assert property (@(posedge i_clk)
    !i_reset |-> (i_pc[1:0] == 2'b00))
    else begin
      $error("PC is not word aligned");
      n_assert_fail++;
    end

  // $0 reads as zero on both ports
  a_zero_port1: assert property (@(posedge i_clk)
    (i_raddr1 == '0) |-> (i_rdata1 == '0))
    else begin
      $error("register 0 read nonzero on port 1");
      n_assert_fail++;
    end
  a_zero_port2: assert property (@(posedge i_clk)
    (i_raddr2 == '0) |-> (i_rdata2 == '0))
    else begin
      $error("register 0 read nonzero on port 2");
      n_assert_fail++;
    end

endmodule

bind mips_core mips_core_props u_props (
  .i_clk     (i_clk),
  .i_reset   (i_reset),
  .i_pc      (o_pc),
  .i_dmem    (o_dmem),
  .i_dmem_re (o_dmem_re),
  .i_reg_we  (reg_we),
  .i_raddr1  (rs),
  .i_raddr2  (rt),
  .i_rdata1  (rdata1),
  .i_rdata2  (rdata2)
);

// File: tb/mips_core_tb.sv
// Testbench for the single-cycle MIPS core
// Random program, instruction-set model, instruction and data memories
// PC, store strobes and store data are compared every cycle

`timescale 1ns/10ps

`include "mips_defs.svh"

module mips_core_tb;

  import mips_pkg::*;

  localparam int N_INIT       = 31;
  localparam int N_RAND       = 200;
  localparam int N_DUMP       = 31;
  localparam int PROG_LEN     = N_INIT + N_RAND + N_DUMP;
  localparam int RESET_CYCLES = 4;
  localparam int MAX_CYCLES   = PROG_LEN + RESET_CYCLES + 20;

  logic        clk;
  logic        reset;
  logic [31:0] instr;
  logic [31:0] pc;
  dmem_req_t   dmem;
  logic        dmem_re;
  logic [31:0] dmem_rdata;

  // Program, DUT-side memory, model state
  logic [31:0] prog [PROG_LEN];
  logic [31:0] mem [64];
  logic [31:0] m_mem [64];
  logic [31:0] m_regs [32];
  logic [31:0] m_pc;

  funct_e fn_list [10] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND,
                           FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
  integer seed;
  int     n_checks;
  int     n_errors;
  int     cycles;

  mips_core dut (
    .i_clk        (clk),
    .i_reset      (reset),
    .i_instr      (instr),
    .o_pc         (pc),
    .o_dmem       (dmem),
    .o_dmem_re    (dmem_re),
    .i_dmem_rdata (dmem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Memory models with combinational read and store at the edge
  ////////////////////////////////////////////////////////////

  // NOP past the end of the program
  assign instr      = (pc[31:2] < PROG_LEN) ? prog[pc[31:2]] : 32'h0000_0000;
  assign dmem_rdata = mem[dmem.addr[7:2]];

  always @(posedge clk) begin
    if (dmem.we) begin
      mem[dmem.addr[7:2]] <= dmem.wdata;
    end
  end

  // Initial memory word built from its byte address
  function automatic logic [31:0] fill_word(input int idx);
    logic [31:0] byte_addr;
    byte_addr = idx * 4;
    return byte_addr ^ {byte_addr[15:0], byte_addr[15:0]} ^ 32'h5a3c_9600;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Program generator
  ////////////////////////////////////////////////////////////

  task automatic gen_program();
    logic [31:0] r;
    logic [31:0] s;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [15:0] off;
    logic [5:0]  op;
    // ADDI rN, $0, imm for every register
    for (int i = 1; i <= N_INIT; i++) begin
      s = $random(seed);
      prog[i-1] = {OP_ADDI, 5'd0, i[4:0], s[15:0]};
    end
    for (int i = N_INIT; i < N_INIT + N_RAND; i++) begin
      r   = $random(seed);
      s   = $random(seed);
      rs  = r[12:8];
      rt  = r[17:13];
      rd  = r[22:18];
      off = {8'd0, r[29:24], 2'b00};
      case (r[3:0])
        0, 1, 2: prog[i] = {OP_RTYPE, rs, rt, rd, 5'd0, fn_list[r[7:4] % 10]};
        3, 4: begin
          op      = r[4] ? OP_ADDIU : OP_ADDI;
          prog[i] = {op, rs, rt, s[15:0]};
        end
        5: prog[i] = {OP_SLTI, rs, rt, s[15:0]};
        6, 7: begin
          op      = (r[5:4] == 2'd0) ? OP_ANDI : (r[5:4] == 2'd1) ? OP_ORI : OP_XORI;
          prog[i] = {op, rs, rt, s[15:0]};
        end
        // Memory access from base $0 with a word offset in 64 words
        8, 9:   prog[i] = {OP_LW, 5'd0, rt, off};
        10, 11: prog[i] = {OP_SW, 5'd0, rt, off};
        12, 13, 14: begin
          // Forward by 1 to 4 words with rs == rt half the time
          op      = r[4] ? OP_BNE : OP_BEQ;
          off     = {14'd0, r[31:30]} + 16'd1;
          prog[i] = {op, rs, (r[23] ? rs : rt), off};
        end
        default: prog[i] = {6'h3f, r[25:0]};
      endcase
    end
    // Dump r1..r31 to word N
    for (int i = 1; i <= N_DUMP; i++) begin
      off = i * 4;
      prog[N_INIT + N_RAND + i - 1] = {OP_SW, 5'd0, i[4:0], off};
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Instruction-set model stepping one instruction per call
  ////////////////////////////////////////////////////////////

  task automatic model_step();
    logic [31:0] iw;
    logic [5:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sext;
    logic [31:0] zext;
    logic [31:0] addr;
    logic [31:0] wval;
    logic [31:0] next_pc;
    logic [4:0]  wdst;
    logic        wr;
    logic        st;
    logic        ld;
    iw      = (m_pc[31:2] < PROG_LEN) ? prog[m_pc[31:2]] : 32'h0000_0000;
    op      = iw[31:26];
    a       = m_regs[iw[25:21]];
    b       = m_regs[iw[20:16]];
    sext    = {{16{iw[15]}}, iw[15:0]};
    zext    = {16'd0, iw[15:0]};
    addr    = a + sext;
    next_pc = m_pc + 32'd4;
    wdst    = iw[20:16];
    wval    = '0;
    wr      = 1'b0;
    st      = 1'b0;
    ld      = 1'b0;
    case (op)
      OP_RTYPE: begin
        wr   = 1'b1;
        wdst = iw[15:11];
        case (iw[5:0])
          FN_SUB, FN_SUBU: wval = a - b;
          FN_AND:          wval = a & b;
          FN_OR:           wval = a | b;
          FN_XOR:          wval = a ^ b;
          FN_NOR:          wval = ~(a | b);
          FN_SLT:          wval = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          FN_SLTU:         wval = (a < b) ? 32'd1 : 32'd0;
          default:         wval = a + b;
        endcase
      end
      OP_ADDI, OP_ADDIU: begin
        wr   = 1'b1;
        wval = a + sext;
      end
      OP_SLTI: begin
        wr   = 1'b1;
        wval = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
      end
      OP_ANDI: begin
        wr   = 1'b1;
        wval = a & zext;
      end
      OP_ORI: begin
        wr   = 1'b1;
        wval = a | zext;
      end
      OP_XORI: begin
        wr   = 1'b1;
        wval = a ^ zext;
      end
      OP_LW: begin
        wr   = 1'b1;
        ld   = 1'b1;
        wval = m_mem[addr[7:2]];
      end
      OP_SW: st = 1'b1;
      // Target is PC+4 plus offset words
      OP_BEQ: if (a == b) next_pc = m_pc + 32'd4 + {sext[29:0], 2'b00};
      OP_BNE: if (a != b) next_pc = m_pc + 32'd4 + {sext[29:0], 2'b00};
      default: begin
      end
    endcase

    check_val("o_pc", pc, m_pc);
    check_val("o_dmem.we", {31'd0, dmem.we}, {31'd0, st});
    check_val("o_dmem_re", {31'd0, dmem_re}, {31'd0, ld});
    if (st) begin
      check_val("o_dmem.addr", dmem.addr, addr);
      check_val("o_dmem.wdata", dmem.wdata, b);
    end

    // Commit results with $0 kept at zero
    if (wr && (wdst != 5'd0)) begin
      m_regs[wdst] = wval;
    end
    if (st) begin
      m_mem[addr[7:2]] = b;
    end
    m_pc = next_pc;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and cycle limit
  ////////////////////////////////////////////////////////////

  initial begin
    seed     = 32'he387_c136;
    n_checks = 0;
    n_errors = 0;
    reset    = 1'b1;
    m_pc     = `MIPS_RESET_PC;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
      mem[i]   = fill_word(i);
      m_mem[i] = fill_word(i);
    end
    gen_program();

    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_val("o_pc", pc, `MIPS_RESET_PC);

    // Outputs settle mid-cycle so the falling edge sees stable values
    while (m_pc[31:2] < PROG_LEN) begin
      model_step();
      @(negedge clk);
    end

    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             n_checks, n_errors, dut.u_props.n_assert_fail);
    if ((n_errors == 0) && (dut.u_props.n_assert_fail == 0)) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the program never ran to its end", cycles);
    $display("Test FAILED");
    $finish;
  end

endmodule
